/* hdl/regFile_macros.svh */
`ifndef REGFILE_MACROS_SVH
`define REGFILE_MACROS_SVH

// Datapath widths
`define REG_W	64
`define IMM_W	33	// Bit 32 is the sign
`define ADDR_W	48	// PC and GBR as delivered by the core

`define GPR_N	32

// Special register IDs, upper half of the 6-bit ID space
`define ID_DLR	6'h20
`define ID_DHR	6'h21
`define ID_PC	6'h22
`define ID_GBR	6'h23
`define ID_LR	6'h24
`define ID_SP	6'h2F

// Operand-only IDs, never forwarded
`define ID_IMM	6'h3E
`define ID_ZZR	6'h3F

`endif

/* hdl/regFilePkg.sv */
package regFilePkg;

	// GPR view of a register ID
	typedef struct packed {
		logic       isSpecial;	// Set for DLR, SP, IMM and friends
		logic [4:0] gprIdx;
	} regIdFieldsT;

	// Same 6 bits, either split into fields or matched as a whole code
	typedef union packed {
		regIdFieldsT fld;
		logic [5:0]  code;
	} regIdT;

	typedef logic [63:0] regValT;

	typedef logic [32:0] immT;	// Raw decode immediate

	// Bank holding the live copy of a GPR
	typedef enum logic [1:0] {
		bankA,
		bankB,
		bankC
	} bankSelT;

endpackage

/* hdl/laneBank.sv */
`timescale 1ns/1ps
`include "regFile_macros.svh"

module laneBank (
	input  logic               clock,
	input  logic               wrEn,
	input  logic [4:0]         wrIdx,
	input  regFilePkg::regValT wrVal,
	input  logic [4:0]         rdIdx [6],
	output regFilePkg::regValT rdVal [6]
);
	import regFilePkg::*;

	regValT mem [`GPR_N];

	// Single write port, owned by one lane
	always_ff @(posedge clock)
	begin
		if (wrEn)
			mem[wrIdx] <= wrVal;
	end

	// Six asynchronous read ports
	always_comb
	begin
		for (int p = 0; p < 6; p++)
			rdVal[p] = mem[rdIdx[p]];
	end

endmodule

/* hdl/liveValueTable.sv */
`timescale 1ns/1ps
`include "regFile_macros.svh"

module liveValueTable (
	input  logic                clock,
	input  logic                arstN,
	input  logic                hold,
	input  logic                ex3Flush,
	input  regFilePkg::regIdT   wrIdA,
	input  regFilePkg::regIdT   wrIdB,
	input  regFilePkg::regIdT   wrIdC,
	input  regFilePkg::regIdT   rdId [6],
	output logic                wrEnA,
	output logic                wrEnB,
	output logic                wrEnC,
	output regFilePkg::bankSelT rdBank [6]
);
	import regFilePkg::*;

	logic    wrOpen;
	bankSelT owner [`GPR_N];	// Bank with the newest copy of each GPR

	assign wrOpen = arstN && !hold && !ex3Flush;	// Closed in reset, hold and flush

	// Special IDs never reach the banks
	assign wrEnA = wrOpen && !wrIdA.fld.isSpecial;
	assign wrEnB = wrOpen && !wrIdB.fld.isSpecial;
	assign wrEnC = wrOpen && !wrIdC.fld.isSpecial;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < `GPR_N; i++)
				owner[i] <= bankA;
		end
		else
		begin
			// Last assignment wins, so C beats B beats A on a shared index
			if (wrEnA)
				owner[wrIdA.fld.gprIdx] <= bankA;
			if (wrEnB)
				owner[wrIdB.fld.gprIdx] <= bankB;
			if (wrEnC)
				owner[wrIdC.fld.gprIdx] <= bankC;
		end
	end

	// Steer each read to the owning bank
	always_comb
	begin
		for (int p = 0; p < 6; p++)
			rdBank[p] = owner[rdId[p].fld.gprIdx];	// Ignored by ports for special IDs
	end

endmodule

/* hdl/specialReg.sv */
`timescale 1ns/1ps
`include "regFile_macros.svh"

module specialReg #(
	parameter logic [5:0] regCode = `ID_ZZR
) (
	input  logic               clock,
	input  logic               arstN,
	input  logic               hold,
	input  logic               ex3Flush,
	input  regFilePkg::regIdT  wrIdA,
	input  regFilePkg::regIdT  wrIdB,
	input  regFilePkg::regIdT  wrIdC,
	input  regFilePkg::regValT wrValA,
	input  regFilePkg::regValT wrValB,
	input  regFilePkg::regValT wrValC,
	input  regFilePkg::regValT extIn,
	output regFilePkg::regValT value
);
	import regFilePkg::*;

	regValT nextVal;

	// Outside value unless a lane targets this register, C wins
	always_comb
	begin
		nextVal = extIn;
		if (wrIdA.code == regCode)
			nextVal = wrValA;
		if (wrIdB.code == regCode)
			nextVal = wrValB;
		if (wrIdC.code == regCode)
			nextVal = wrValC;
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			value <= '0;
		else if (!hold && !ex3Flush)	// Frozen along with the banks
			value <= nextVal;
	end

endmodule

/* hdl/operandPort.sv */
`timescale 1ns/1ps
`include "regFile_macros.svh"

// fwdId/fwdVal order is A1 B1 C1 A2 B2 C2 A3 B3 C3, lowest index newest
module operandPort #(
	parameter bit hasCtrlRegs = 1'b0
) (
	input  regFilePkg::regIdT   srcId,
	input  regFilePkg::bankSelT bank,
	input  regFilePkg::regValT  bankValA,
	input  regFilePkg::regValT  bankValB,
	input  regFilePkg::regValT  bankValC,
	input  regFilePkg::regValT  dlr,
	input  regFilePkg::regValT  dhr,
	input  regFilePkg::regValT  sp,
	input  regFilePkg::regValT  lr,
	input  logic [`ADDR_W-1:0]  pc,
	input  logic [`ADDR_W-1:0]  gbr,
	input  regFilePkg::immT     imm,
	input  regFilePkg::regIdT   fwdId [9],
	input  regFilePkg::regValT  fwdVal [9],
	output regFilePkg::regValT  value
);
	import regFilePkg::*;

	localparam int LO_W = 32;	// Control regs read back as 32-bit values

	regValT baseVal;
	logic   noFwd;

	// Decode the ID into a stored or synthesized value
	always_comb
	begin
		baseVal = '0;
		noFwd   = 1'b0;
		if (!srcId.fld.isSpecial)
		begin
			case (bank)
				bankB:   baseVal = bankValB;
				bankC:   baseVal = bankValC;
				default: baseVal = bankValA;
			endcase
		end
		else
		begin
			case (srcId.code)
				`ID_DLR: baseVal = dlr;
				`ID_DHR: baseVal = dhr;
				`ID_SP:  baseVal = sp;
				`ID_PC:
				begin
					if (hasCtrlRegs)
						baseVal = {{(`REG_W-LO_W){1'b0}}, pc[LO_W-1:1], 1'b0};	// Bit 0 dropped
				end
				`ID_GBR:
				begin
					if (hasCtrlRegs)
						baseVal = {{(`REG_W-LO_W){1'b0}}, gbr[LO_W-1:0]};
				end
				`ID_LR:
				begin
					if (hasCtrlRegs)
						baseVal = {{(`REG_W-LO_W){1'b0}}, lr[LO_W-1:0]};
				end
				`ID_IMM:
				begin
					baseVal = {{(`REG_W-`IMM_W+1){imm[`IMM_W-1]}}, imm[`IMM_W-2:0]};
					noFwd   = 1'b1;
				end
				`ID_ZZR: noFwd = 1'b1;	// Reads zero
				default: ;	// Unknown IDs read zero
			endcase
		end
	end

	// Walk oldest to newest so the newest match is left standing
	always_comb
	begin
		value = baseVal;
		if (!noFwd)
		begin
			for (int i = 8; i >= 0; i--)
			begin
				if (fwdId[i].code == srcId.code)
					value = fwdVal[i];
			end
		end
	end

endmodule

/* hdl/regFileTop.sv */
`timescale 1ns/1ps
`include "regFile_macros.svh"

module regFileTop (
	input  logic               clock,
	input  logic               arstN,
	input  logic               hold,

	input  regFilePkg::regIdT  regIdRs,
	input  regFilePkg::regIdT  regIdRt,
	input  regFilePkg::regIdT  regIdRu,
	input  regFilePkg::regIdT  regIdRv,
	input  regFilePkg::regIdT  regIdRx,
	input  regFilePkg::regIdT  regIdRy,
	output regFilePkg::regValT regValRs,
	output regFilePkg::regValT regValRt,
	output regFilePkg::regValT regValRu,
	output regFilePkg::regValT regValRv,
	output regFilePkg::regValT regValRx,
	output regFilePkg::regValT regValRy,

	input  regFilePkg::regIdT  regIdRnA1,
	input  regFilePkg::regValT regValRnA1,
	input  regFilePkg::regIdT  regIdRnB1,
	input  regFilePkg::regValT regValRnB1,
	input  regFilePkg::regIdT  regIdRnC1,
	input  regFilePkg::regValT regValRnC1,
	input  regFilePkg::regIdT  regIdRnA2,
	input  regFilePkg::regValT regValRnA2,
	input  regFilePkg::regIdT  regIdRnB2,
	input  regFilePkg::regValT regValRnB2,
	input  regFilePkg::regIdT  regIdRnC2,
	input  regFilePkg::regValT regValRnC2,
	input  regFilePkg::regIdT  regIdRnA3,	// EX3 lanes write back
	input  regFilePkg::regValT regValRnA3,
	input  regFilePkg::regIdT  regIdRnB3,
	input  regFilePkg::regValT regValRnB3,
	input  regFilePkg::regIdT  regIdRnC3,
	input  regFilePkg::regValT regValRnC3,
	input  logic               ex3Flush,

	input  logic [`ADDR_W-1:0] regValPc,
	input  logic [`ADDR_W-1:0] regValGbr,
	input  regFilePkg::regValT regValLr,
	input  regFilePkg::immT    regValImmA,
	input  regFilePkg::immT    regValImmB,
	input  regFilePkg::immT    regValImmC,

	input  regFilePkg::regValT regInDlr,
	input  regFilePkg::regValT regInDhr,
	input  regFilePkg::regValT regInSp,
	output regFilePkg::regValT regOutDlr,
	output regFilePkg::regValT regOutDhr,
	output regFilePkg::regValT regOutSp
);
	import regFilePkg::*;

	regIdT   srcId [6];
	regValT  portVal [6];
	bankSelT portBank [6];
	logic [4:0] rdIdx [6];
	immT     laneImm [3];

	regIdT   wrId [3];
	regValT  wrVal [3];
	logic    wrEn [3];
	regValT  bankRd [3][6];	// [bank][port]

	regIdT   fwdId [9];
	regValT  fwdVal [9];

	assign srcId   = '{regIdRs, regIdRt, regIdRu, regIdRv, regIdRx, regIdRy};
	assign laneImm = '{regValImmA, regValImmB, regValImmC};
	assign wrId    = '{regIdRnA3, regIdRnB3, regIdRnC3};
	assign wrVal   = '{regValRnA3, regValRnB3, regValRnC3};

	// Newest stage first, lane A first within a stage
	assign fwdId  = '{regIdRnA1, regIdRnB1, regIdRnC1,
		regIdRnA2, regIdRnB2, regIdRnC2,
		regIdRnA3, regIdRnB3, regIdRnC3};
	assign fwdVal = '{regValRnA1, regValRnB1, regValRnC1,
		regValRnA2, regValRnB2, regValRnC2,
		regValRnA3, regValRnB3, regValRnC3};

	assign regValRs = portVal[0];
	assign regValRt = portVal[1];
	assign regValRu = portVal[2];
	assign regValRv = portVal[3];
	assign regValRx = portVal[4];
	assign regValRy = portVal[5];

	liveValueTable i_lvt (
		.clock    (clock),
		.arstN    (arstN),
		.hold     (hold),
		.ex3Flush (ex3Flush),
		.wrIdA    (regIdRnA3),
		.wrIdB    (regIdRnB3),
		.wrIdC    (regIdRnC3),
		.rdId     (srcId),
		.wrEnA    (wrEn[0]),
		.wrEnB    (wrEn[1]),
		.wrEnC    (wrEn[2]),
		.rdBank   (portBank)
	);

	// One bank per write lane
	for (genvar b = 0; b < 3; b++)
	begin : g_bank
		laneBank i_bank (
			.clock (clock),
			.wrEn  (wrEn[b]),
			.wrIdx (wrId[b].fld.gprIdx),
			.wrVal (wrVal[b]),
			.rdIdx (rdIdx),
			.rdVal (bankRd[b])
		);
	end

	specialReg #(.regCode(`ID_DLR)) i_dlr (
		.clock (clock), .arstN (arstN), .hold (hold), .ex3Flush (ex3Flush),
		.wrIdA (regIdRnA3), .wrIdB (regIdRnB3), .wrIdC (regIdRnC3),
		.wrValA (regValRnA3), .wrValB (regValRnB3), .wrValC (regValRnC3),
		.extIn (regInDlr), .value (regOutDlr)
	);

	specialReg #(.regCode(`ID_DHR)) i_dhr (
		.clock (clock), .arstN (arstN), .hold (hold), .ex3Flush (ex3Flush),
		.wrIdA (regIdRnA3), .wrIdB (regIdRnB3), .wrIdC (regIdRnC3),
		.wrValA (regValRnA3), .wrValB (regValRnB3), .wrValC (regValRnC3),
		.extIn (regInDhr), .value (regOutDhr)
	);

	specialReg #(.regCode(`ID_SP)) i_sp (
		.clock (clock), .arstN (arstN), .hold (hold), .ex3Flush (ex3Flush),
		.wrIdA (regIdRnA3), .wrIdB (regIdRnB3), .wrIdC (regIdRnC3),
		.wrValA (regValRnA3), .wrValB (regValRnB3), .wrValC (regValRnC3),
		.extIn (regInSp), .value (regOutSp)
	);

	// Port pairs share a lane immediate, only Rs sees PC, GBR and LR
	for (genvar p = 0; p < 6; p++)
	begin : g_port
		assign rdIdx[p] = srcId[p].fld.gprIdx;

		operandPort #(.hasCtrlRegs(p == 0)) i_port (
			.srcId    (srcId[p]),
			.bank     (portBank[p]),
			.bankValA (bankRd[0][p]),
			.bankValB (bankRd[1][p]),
			.bankValC (bankRd[2][p]),
			.dlr      (regOutDlr),
			.dhr      (regOutDhr),
			.sp       (regOutSp),
			.lr       (regValLr),
			.pc       (regValPc),
			.gbr      (regValGbr),
			.imm      (laneImm[p/2]),
			.fwdId    (fwdId),
			.fwdVal   (fwdVal),
			.value    (portVal[p])
		);
	end

endmodule

/* testbench/regFile_props.sv */
`timescale 1ns/1ps

// Write gating checks, bound into every liveValueTable
module regFileProps (
	input logic              clock,
	input logic              arstN,
	input logic              hold,
	input logic              ex3Flush,
	input regFilePkg::regIdT wrIdA,
	input regFilePkg::regIdT wrIdB,
	input regFilePkg::regIdT wrIdC,
	input logic              wrEnA,
	input logic              wrEnB,
	input logic              wrEnC
);
	logic anyEn;

	assign anyEn = wrEnA || wrEnB || wrEnC;

	aFrozen: assert property (@(posedge clock) disable iff (!arstN)
		(hold || ex3Flush) |-> !anyEn)
		else $error("Bank write enabled while hold or ex3Flush is high");

	// Specials live outside the banks
	aNoSpecial: assert property (@(posedge clock) disable iff (!arstN)
		!((wrIdA.fld.isSpecial && wrEnA) || (wrIdB.fld.isSpecial && wrEnB) ||
		(wrIdC.fld.isSpecial && wrEnC)))
		else $error("Bank write enabled for a special register ID");

	aResetQuiet: assert property (@(posedge clock) !arstN |-> !anyEn)
		else $error("Bank write enabled during reset");

endmodule

bind liveValueTable regFileProps i_props (
	.clock    (clock),
	.arstN    (arstN),
	.hold     (hold),
	.ex3Flush (ex3Flush),
	.wrIdA    (wrIdA),
	.wrIdB    (wrIdB),
	.wrIdC    (wrIdC),
	.wrEnA    (wrEnA),
	.wrEnB    (wrEnB),
	.wrEnC    (wrEnC)
);

/* testbench/regFileTb.sv */
`timescale 1ns/1ps
`include "regFile_macros.svh"

module regFileTb;

	logic        clock;
	logic        arstN;
	logic        hold;
	logic        ex3Flush;
	logic [5:0]  srcId [6];
	logic [63:0] portVal [6];
	logic [5:0]  fwdId [9];	// A1 B1 C1 A2 B2 C2 A3 B3 C3, EX3 also writes
	logic [63:0] fwdVal [9];
	logic [47:0] pc;
	logic [47:0] gbr;
	logic [63:0] lr;
	logic [32:0] imm [3];
	logic [63:0] extIn [3];	// DLR, DHR, SP
	logic [63:0] extOut [3];

	logic [63:0] f [18];	// Fields of the current stimulus record
	int          mismatchCnt;
	int          otherErrCnt;
	int          checkCnt;
	int          waitCnt;

	string portName [6] = '{"regValRs", "regValRt", "regValRu", "regValRv", "regValRx",
		"regValRy"};
	string outName [3] = '{"regOutDlr", "regOutDhr", "regOutSp"};

	regFileTop i_dut (
		.clock      (clock),
		.arstN      (arstN),
		.hold       (hold),
		.regIdRs    (srcId[0]), .regValRs (portVal[0]),
		.regIdRt    (srcId[1]), .regValRt (portVal[1]),
		.regIdRu    (srcId[2]), .regValRu (portVal[2]),
		.regIdRv    (srcId[3]), .regValRv (portVal[3]),
		.regIdRx    (srcId[4]), .regValRx (portVal[4]),
		.regIdRy    (srcId[5]), .regValRy (portVal[5]),
		.regIdRnA1  (fwdId[0]), .regValRnA1 (fwdVal[0]),
		.regIdRnB1  (fwdId[1]), .regValRnB1 (fwdVal[1]),
		.regIdRnC1  (fwdId[2]), .regValRnC1 (fwdVal[2]),
		.regIdRnA2  (fwdId[3]), .regValRnA2 (fwdVal[3]),
		.regIdRnB2  (fwdId[4]), .regValRnB2 (fwdVal[4]),
		.regIdRnC2  (fwdId[5]), .regValRnC2 (fwdVal[5]),
		.regIdRnA3  (fwdId[6]), .regValRnA3 (fwdVal[6]),
		.regIdRnB3  (fwdId[7]), .regValRnB3 (fwdVal[7]),
		.regIdRnC3  (fwdId[8]), .regValRnC3 (fwdVal[8]),
		.ex3Flush   (ex3Flush),
		.regValPc   (pc),
		.regValGbr  (gbr),
		.regValLr   (lr),
		.regValImmA (imm[0]),
		.regValImmB (imm[1]),
		.regValImmC (imm[2]),
		.regInDlr   (extIn[0]),
		.regInDhr   (extIn[1]),
		.regInSp    (extIn[2]),
		.regOutDlr  (extOut[0]),
		.regOutDhr  (extOut[1]),
		.regOutSp   (extOut[2])
	);

	always #5 clock = ~clock;

	initial
	begin
		arstN = 1'b0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		arstN <= 1'b1;
	end

	// Idle pipeline, ZZR never forwards or writes
	task automatic clearStages();
		for (int i = 0; i < 9; i++)
		begin
			fwdId[i]  = `ID_ZZR;
			fwdVal[i] = '0;
		end
	endtask

	task automatic stepCycle();
		@(posedge clock);
		@(negedge clock);
		clearStages();
	endtask

	task automatic checkVal(input string name, input logic [63:0] expVal,
		input logic [63:0] actVal);
		checkCnt++;
		if (actVal !== expVal)
		begin
			$display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expVal,
				actVal);
			mismatchCnt++;
		end
	endtask

	task automatic applyRecord(input logic [7:0] kind);
		case (kind)
			"W":
			begin
				hold     = f[0][0];
				ex3Flush = f[1][0];
				for (int i = 0; i < 3; i++)
				begin
					fwdId[6+i]  = f[2+2*i][5:0];
					fwdVal[6+i] = f[3+2*i];
					extIn[i]    = f[8+i];
				end
				stepCycle();
			end
			"F":
			begin
				for (int i = 0; i < 9; i++)
				begin
					fwdId[i]  = f[2*i][5:0];
					fwdVal[i] = f[2*i+1];
				end
			end
			"K":
			begin
				pc  = f[0][47:0];
				gbr = f[1][47:0];
				lr  = f[2];
				for (int i = 0; i < 3; i++)
					imm[i] = f[3+i][32:0];
			end
			"R":
			begin
				for (int p = 0; p < 6; p++)
					srcId[p] = f[p][5:0];
				#4;	// 1 ns ahead of the rising edge
				for (int p = 0; p < 6; p++)
					checkVal(portName[p], f[6+p], portVal[p]);
				stepCycle();
			end
			default:	// O, registered outputs are settled at the falling edge
			begin
				for (int i = 0; i < 3; i++)
					checkVal(outName[i], f[i], extOut[i]);
			end
		endcase
	endtask

	task automatic runStimulus();
		int               fd;
		int               need;
		int               nRead;
		logic [7:0]       kind;
		logic [8*256-1:0] junk;

		fd = $fopen("testbench/regFile_stim.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open testbench/regFile_stim.txt");
			otherErrCnt++;
			return;
		end
		while ($fscanf(fd, " %c", kind) == 1)
		begin
			case (kind)
				"#":     need = -1;
				"W":     need = 11;
				"F":     need = 18;
				"K":     need = 6;
				"R":     need = 12;
				"O":     need = 3;
				default: need = 0;
			endcase
			if (need < 0)
				nRead = $fgets(junk, fd);	// Rest of a comment line
			else
			begin
				nRead = 0;
				for (int i = 0; i < need; i++)
					nRead += $fscanf(fd, " %h", f[i]);
				if (need == 0 || nRead != need)
				begin
					$display("Malformed stimulus record of kind '%c'", kind);
					otherErrCnt++;
					break;
				end
				applyRecord(kind);
			end
		end
		$fclose(fd);
	endtask

	initial
	begin
		clock       = 1'b0;
		hold        = 1'b0;
		ex3Flush    = 1'b0;
		pc          = '0;
		gbr         = '0;
		lr          = '0;
		mismatchCnt = 0;
		otherErrCnt = 0;
		checkCnt    = 0;
		for (int i = 0; i < 6; i++)
			srcId[i] = `ID_ZZR;
		for (int i = 0; i < 3; i++)
		begin
			imm[i]   = '0;
			extIn[i] = '0;
		end
		clearStages();
		// Lanes aim at GPRs throughout reset
		for (int i = 0; i < 3; i++)
			fwdId[6+i] = 6'(i);

		waitCnt = 0;
		while (arstN !== 1'b1 && waitCnt < 20)
		begin
			@(negedge clock);
			waitCnt++;
		end
		if (arstN !== 1'b1)
		begin
			$display("Reset was not released within 20 cycles");
			otherErrCnt++;
		end
		else
		begin
			clearStages();
			runStimulus();
		end

		if (checkCnt == 0)
		begin
			$display("No checks were run");
			otherErrCnt++;
		end
		$display("Summary: %0d checks, %0d mismatches, %0d other errors", checkCnt,
			mismatchCnt, otherErrCnt);
		if (mismatchCnt == 0 && otherErrCnt == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* testbench/regFile_stim.txt */
# W hold flush idA3 valA3 idB3 valB3 idC3 valC3 inDlr inDhr inSp | K pc gbr lr immA immB immC
# F idA1 valA1 .. idC3 valC3 | R idRs..idRy expRs..expRy | O expDlr expDhr expSp (all hex)
W 0 0 00 a0000000000 01 a0100000001 02 a0200000002 0 0 0
W 0 0 05 a0500000005 03 a0300000003 04 a0400000004 0 0 0
W 0 0 07 a0700000007 08 a0800000008 06 a0600000006 0 0 0
W 0 0 09 a0900000009 0b a0b0000000b 0a a0a0000000a 0 0 0
W 0 0 0e a0e0000000e 0c a0c0000000c 0d a0d0000000d 0 0 0
W 0 0 0f a0f0000000f 10 a1000000010 11 a1100000011 0 0 0
W 0 0 14 a1400000014 12 a1200000012 13 a1300000013 0 0 0
W 0 0 15 a1500000015 17 a1700000017 16 a1600000016 0 0 0
W 0 0 18 a1800000018 19 a1900000019 1a a1a0000001a 0 0 0
W 0 0 1d a1d0000001d 1b a1b0000001b 1c a1c0000001c 0 0 0
W 0 0 1f bad1 1f bad2 1f a1f0000001f 0 0 0
W 0 0 1e a1e0000001e 3f 0 3f 0 0 0 0
R 00 01 02 03 04 05 a0000000000 a0100000001 a0200000002 a0300000003 a0400000004 a0500000005
R 06 07 08 09 0a 0b a0600000006 a0700000007 a0800000008 a0900000009 a0a0000000a a0b0000000b
R 0c 0d 0e 0f 10 11 a0c0000000c a0d0000000d a0e0000000e a0f0000000f a1000000010 a1100000011
R 12 13 14 15 16 17 a1200000012 a1300000013 a1400000014 a1500000015 a1600000016 a1700000017
R 18 19 1a 1b 1c 1d a1800000018 a1900000019 a1a0000001a a1b0000001b a1c0000001c a1d0000001d
R 1e 1f 1f 1f 1f 1f a1e0000001e a1f0000001f a1f0000001f a1f0000001f a1f0000001f a1f0000001f
# Hold, then flush, both freeze GPRs and the special reload
W 1 0 00 dead 20 77 3f 0 11 22 33
W 0 1 01 dead 2f 77 3f 0 11 22 33
O 0 0 0
R 00 20 21 2f 01 02 a0000000000 0 0 0 a0100000001 a0200000002
# Specials reload from outside unless a lane writes them
W 0 0 3f 0 3f 0 3f 0 111 222 333
O 111 222 333
W 0 0 20 d1a 20 d1b 2f 5c 444 555 666
O d1b 555 5c
R 20 21 2f 20 21 2f d1b 555 5c d1b 555 5c
# Immediates, ZZR and control registers
K a5a5f00dbeef 777712345678 fedcba9876543210 100000005 012345678 180000000
F 3e 999 3f 888 3f 0 3f 0 3f 0 3f 0 3f 0 3f 0 3f 0
R 22 3e 3e 3f 3e 22 f00dbeee ffffffff00000005 12345678 0 ffffffff80000000 0
R 23 24 23 24 3f 30 12345678 0 0 0 0 0
R 24 23 22 30 3f 3f 76543210 0 0 0 0 0
# Forwarding priority, EX3 entries land in storage on the check cycle
F 01 11a 01 11b 02 11c 01 21a 02 21b 03 21c 03 31a 04 31b 04 31c
R 01 02 03 04 05 2f 11a 11c 21c 31b a0500000005 666
F 3f 0 3f 0 3f 0 3f 0 06 22b 06 22c 06 33a 3f 0 07 33c
R 03 04 06 07 08 20 31a 31c 22b 33c a0800000008 444
R 06 07 03 04 00 21 33a 33c 31a 31c a0000000000 555

/* src.f */
+incdir+hdl
hdl/regFilePkg.sv
hdl/laneBank.sv
hdl/liveValueTable.sv
hdl/specialReg.sv
hdl/operandPort.sv
hdl/regFileTop.sv
testbench/regFile_props.sv
testbench/regFileTb.sv

/* Makefile */
TOP := regFileTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir -o simv
	./obj_dir/simv | tee sim.log
	grep -qx '\*\*\* TEST PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
